//--- vlog.f
source/mipsPkg.sv
source/stageRegister.sv
source/controlDecoder.sv
source/hazardUnit.sv
source/registerFile.sv
source/alu.sv
source/dataBusMaster.sv
source/mipsCore.sv
sim/wishboneMemory.sv
sim/mipsCoreTb.sv

//--- run.sh
#!/bin/sh
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module mipsCoreTb -f vlog.f -o mipsCoreTb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/mipsCoreTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1

//--- sim/mipsCoreTb.sv
`default_nettype none

module mipsCoreTb;
    timeunit 1ns;
    timeprecision 1ps;
    import mipsPkg::*;

    localparam int resetCycles = 16;
    localparam int totalInstructions = 6 * 48;
    localparam int cycleLimit = totalInstructions * 20;

    logic clock, reset, clearLog;
    logic [1:0] waitStates;
    word_t instAddress, instData, busWriteData, busReadData;
    logic busCyc, busStb, busWe, busAck;
    logic [wordAddrWidth-1:0] busAddress;

    word_t rom [256];
    int pcIndex;
    int cycleCount = 0;
    int valueErrors = 0;
    int otherErrors = 0;
    word_t randomState = 32'd76657;
    logic [wordAddrWidth-1:0] expAddr [$];
    word_t expData [$];
    word_t a, b;
    logic [15:0] imm;
    logic [4:0] sh;

    assign instData = rom[instAddress[9:2]];

    mipsCore UUT (
        .clock(clock), .reset(reset), .instAddress(instAddress), .instData(instData),
        .busCyc(busCyc), .busStb(busStb), .busWe(busWe), .busAddress(busAddress),
        .busWriteData(busWriteData), .busAck(busAck), .busReadData(busReadData)
    );

    wishboneMemory memory (
        .clock(clock), .waitStates(waitStates), .clearLog(clearLog),
        .busCyc(busCyc), .busStb(busStb), .busWe(busWe), .busAddress(busAddress),
        .busWriteData(busWriteData), .busAck(busAck), .busReadData(busReadData)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout after %0d cycles, the expected stores never arrived", cycleCount);
            $display("Test failed");
            $finish;
        end
    end

    function word_t xorshift();
        randomState = randomState ^ (randomState << 13);
        randomState = randomState ^ (randomState >> 17);
        randomState = randomState ^ (randomState << 5);
        return randomState;
    endfunction

    function word_t rType(logic [5:0] fn, int rs, int rt, int rd, logic [4:0] shamt);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), shamt, fn};
    endfunction

    function word_t iType(logic [5:0] op, int rs, int rt, logic [15:0] value);
        return {op, 5'(rs), 5'(rt), value};
    endfunction

    task automatic emit(word_t instr);
        rom[pcIndex] = instr;
        pcIndex++;
    endtask

    task automatic loadConstant(int rd, word_t value);
        emit(iType(opLui, 0, rd, value[31:16]));
        emit(iType(opOri, rd, rd, value[15:0]));
    endtask

    task automatic store(int rt, int offset);
        emit(iType(opSw, 0, rt, 16'(offset)));
    endtask

    task automatic branch(logic [5:0] op, int rs, int rt, int target);
        emit(iType(op, rs, rt, 16'(target - pcIndex - 1)));
    endtask

    task automatic endLoop();
        emit({opJ, 26'(pcIndex)});   // Jumps to itself
        emit(32'h0);
    endtask

    task automatic expectStore(int offset, word_t value);
        expAddr.push_back(wordAddrWidth'(offset >> 2));
        expData.push_back(value);
    endtask

    task automatic checkWord(word_t actual, word_t expected, string what);
        if (actual !== expected) begin
            valueErrors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic checkAddress(logic [wordAddrWidth-1:0] actual,
                                logic [wordAddrWidth-1:0] expected, string what);
        if (actual !== expected) begin
            valueErrors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic checkBit(logic actual, logic expected, string what);
        if (actual !== expected) begin
            valueErrors++;
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    // Hold the core in reset while a new program goes into the ROM
    task automatic startProgram();
        @(negedge clock);
        reset = 1'b1;
        clearLog = 1'b1;
        for (int i = 0; i < 256; i++) begin
            rom[i] = 32'h0;
        end
        pcIndex = 0;
        expAddr.delete();
        expData.delete();
    endtask

    task automatic runProgram(logic [1:0] waits, string name);
        waitStates = waits;
        repeat (resetCycles) @(negedge clock);
        // Bus idle and fetch at the reset vector before the core starts
        checkBit(busCyc, 1'b0, {name, " busCyc in reset"});
        checkBit(busStb, 1'b0, {name, " busStb in reset"});
        checkBit(busWe, 1'b0, {name, " busWe in reset"});
        checkWord(instAddress, resetVector, {name, " first fetch address"});
        reset = 1'b0;
        clearLog = 1'b0;
        while (memory.logCount < expAddr.size()) @(negedge clock);
        repeat (20) @(negedge clock);   // Catch any extra store
        if (memory.logCount != expAddr.size()) begin
            otherErrors++;
            $display("%s made %0d stores where %0d were expected",
                     name, memory.logCount, expAddr.size());
        end
        for (int i = 0; i < expAddr.size() && i < memory.logCount; i++) begin
            checkAddress(memory.logAddress[i], expAddr[i],
                         $sformatf("%s store %0d address", name, i));
            checkWord(memory.logData[i], expData[i], $sformatf("%s store %0d data", name, i));
        end
    endtask

    task automatic aluStep(word_t instr, word_t expected);
        int offset;
        offset = 32'h100 + 4 * expAddr.size();
        emit(instr);
        store(3, offset);   // Store data forwarded from memory stage
        expectStore(offset, expected);
    endtask

    task automatic aluTest(logic [1:0] waits, string name);
        word_t sext, zext;
        sext = {{16{imm[15]}}, imm};
        zext = {16'h0, imm};
        startProgram();
        loadConstant(1, a);
        loadConstant(2, b);
        aluStep(rType(fnAddu, 1, 2, 3, 0), a + b);
        aluStep(rType(fnSubu, 1, 2, 3, 0), a - b);
        aluStep(rType(fnAnd, 1, 2, 3, 0), a & b);
        aluStep(rType(fnOr, 1, 2, 3, 0), a | b);
        aluStep(rType(fnXor, 1, 2, 3, 0), a ^ b);
        aluStep(rType(fnNor, 1, 2, 3, 0), ~(a | b));
        aluStep(rType(fnSlt, 1, 2, 3, 0), ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        aluStep(rType(fnSll, 0, 2, 3, sh), b << sh);
        aluStep(rType(fnSrl, 0, 2, 3, sh), b >> sh);
        aluStep(iType(opAddiu, 1, 3, imm), a + sext);
        aluStep(iType(opAndi, 1, 3, imm), a & zext);
        aluStep(iType(opOri, 1, 3, imm), a | zext);
        aluStep(iType(opXori, 1, 3, imm), a ^ zext);
        aluStep(iType(opSlti, 1, 3, imm), ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0);
        aluStep(iType(opLui, 0, 3, imm), {imm, 16'h0});
        endLoop();
        runProgram(waits, name);
    endtask

    task automatic dependencyTest();
        startProgram();
        loadConstant(1, a);
        loadConstant(2, b);
        emit(rType(fnAddu, 1, 2, 3, 0));
        emit(rType(fnSubu, 3, 1, 4, 0));   // r3 from memory stage
        emit(rType(fnXor, 4, 3, 5, 0));    // r4 from memory, r3 from writeback
        store(3, 32'h180);
        store(4, 32'h184);
        store(5, 32'h188);
        endLoop();
        expectStore(32'h180, a + b);
        expectStore(32'h184, a + b - a);
        expectStore(32'h188, (a + b - a) ^ (a + b));
        runProgram(2'd0, "dependency");
    endtask

    task automatic loadUseTest();
        startProgram();
        loadConstant(1, a);
        store(1, 32'h200);
        emit(iType(opLw, 0, 2, 16'h200));
        emit(iType(opAddiu, 2, 3, imm));   // Needs the load one cycle early
        store(3, 32'h204);
        endLoop();
        expectStore(32'h200, a);
        expectStore(32'h204, a + {{16{imm[15]}}, imm});
        runProgram(2'd1, "load-use");
    endtask

    task automatic branchTest();
        int base;
        startProgram();
        loadConstant(1, a);
        loadConstant(2, a);
        loadConstant(3, a ^ 32'd1);
        base = pcIndex;
        branch(opBeq, 1, 2, base + 3);   // Taken
        store(1, 32'h300);
        store(1, 32'h304);
        store(1, 32'h308);
        branch(opBeq, 1, 3, base + 7);   // Not taken
        store(1, 32'h30c);
        store(1, 32'h310);
        store(1, 32'h314);
        branch(opBne, 1, 3, base + 11);
        store(1, 32'h318);
        store(1, 32'h31c);
        store(1, 32'h320);
        emit({opJ, 26'(base + 15)});
        store(1, 32'h324);
        store(1, 32'h328);
        store(1, 32'h32c);
        endLoop();
        expectStore(32'h300, a);
        expectStore(32'h308, a);
        expectStore(32'h30c, a);
        expectStore(32'h310, a);
        expectStore(32'h314, a);
        expectStore(32'h318, a);
        expectStore(32'h320, a);
        expectStore(32'h324, a);
        expectStore(32'h32c, a);
        runProgram(2'd0, "branch");
    endtask

    task automatic linkTest();
        startProgram();
        emit(32'h0);
        emit({opJal, 26'd6});                // At byte address 4
        emit(32'h0);
        store(31, 32'h400);
        endLoop();
        store(31, 32'h404);                  // Subroutine at index 6
        emit(rType(fnJr, 31, 0, 0, 0));
        emit(32'h0);
        expectStore(32'h404, 32'd12);
        expectStore(32'h400, 32'd12);
        runProgram(2'd2, "link");
    endtask

    initial begin
        reset = 1'b1;
        clearLog = 1'b1;
        waitStates = 2'd0;
        for (int i = 0; i < 256; i++) begin
            rom[i] = 32'h0;
        end
        a = xorshift();
        b = xorshift();
        imm = 16'(xorshift() >> 16);
        sh = 5'(xorshift() >> 27);
        aluTest(2'd0, "alu");
        dependencyTest();
        loadUseTest();
        branchTest();
        linkTest();
        aluTest(2'd3, "alu with wait states");
        $display("Finished with %0d value errors and %0d other errors", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/wishboneMemory.sv
`default_nettype none

module wishboneMemory (
    input  logic                               clock,
    input  logic [1:0]                         waitStates,
    input  logic                               clearLog,
    input  logic                               busCyc,
    input  logic                               busStb,
    input  logic                               busWe,
    input  logic [mipsPkg::wordAddrWidth-1:0]  busAddress,
    input  mipsPkg::word_t                     busWriteData,
    output logic                               busAck,
    output mipsPkg::word_t                     busReadData
);
    timeunit 1ns;
    timeprecision 1ps;
    import mipsPkg::*;

    word_t                    memory [256];
    logic [wordAddrWidth-1:0] logAddress [64];   // Acknowledged writes, in order
    word_t                    logData [64];
    int                       logCount;
    logic [1:0]               waitCount;

    initial begin
        for (int i = 0; i < 256; i++) begin
            memory[i] = 32'hA5C30000 ^ (i * 32'h0101);
        end
        waitCount = '0;
        logCount = 0;
    end

    assign busAck = busCyc && busStb && (waitCount == waitStates);
    assign busReadData = memory[busAddress[7:0]];

    always @(posedge clock) begin
        if (!(busCyc && busStb) || busAck) begin
            waitCount <= '0;
        end else begin
            waitCount <= waitCount + 2'd1;
        end
        if (clearLog) begin
            logCount <= 0;
        end else if (busAck && busWe) begin
            memory[busAddress[7:0]] <= busWriteData;
            logAddress[logCount[5:0]] <= busAddress;
            logData[logCount[5:0]] <= busWriteData;
            logCount <= logCount + 1;
        end
    end

endmodule

`default_nettype wire

//--- source/mipsCore.sv
`default_nettype none

module mipsCore (
    input  logic                               clock,
    input  logic                               reset,
    output mipsPkg::word_t                     instAddress,
    input  mipsPkg::word_t                     instData,
    output logic                               busCyc,
    output logic                               busStb,
    output logic                               busWe,
    output logic [mipsPkg::wordAddrWidth-1:0]  busAddress,
    output mipsPkg::word_t                     busWriteData,
    input  logic                               busAck,
    input  mipsPkg::word_t                     busReadData
);
    import mipsPkg::*;

    word_t         pc, pcPlus4, nextPc;
    ifIdPayload_t  ifIdIn, ifId;
    idExPayload_t  idExIn, idEx;
    exMemPayload_t exMemIn, exMem;
    memWbPayload_t memWbIn, memWb;

    exControl_t  idControl;
    pcSource_t   pcSource;
    forwardSel_t idForwardA, idForwardB, exForwardA, exForwardB;
    logic        signExtend, useRs, useRt, branchUsesOperands, busWait;
    logic        stallFetch, stallDecode, stallExecute, stallMemory, flushExecute;
    regAddr_t    idRs, idRt, idDestination;
    word_t       regDataA, regDataB, idOperandA, idOperandB;
    word_t       immediate, branchTarget, jumpTarget;
    word_t       exOperandA, exOperandB, aluOperandB, aluResult, loadData, writebackValue;

    // Fetch
    assign pcPlus4 = pc + 32'd4;
    assign instAddress = {pc[dataWidth-1:2], 2'b00};
    assign ifIdIn = '{instruction: instData, pcPlus4: pcPlus4};

    always_comb begin
        case (pcSource)
            pcJump:     nextPc = jumpTarget;
            pcBranch:   nextPc = branchTarget;
            pcRegister: nextPc = idOperandA;   // JR
            default:    nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= resetVector;
        end else if (!stallFetch) begin
            pc <= nextPc;
        end
    end

    stageRegister #(.payload_t(ifIdPayload_t)) ifIdRegister (
        .clock(clock), .reset(reset), .stall(stallDecode), .flush(1'b0),
        .dataIn(ifIdIn), .dataOut(ifId)
    );

    // Decode
    assign idRs = ifId.instruction[25:21];
    assign idRt = ifId.instruction[20:16];
    assign immediate = signExtend ? {{16{ifId.instruction[15]}}, ifId.instruction[15:0]}
                                  : {16'h0000, ifId.instruction[15:0]};
    assign branchTarget = ifId.pcPlus4 + {immediate[29:0], 2'b00};
    assign jumpTarget = {ifId.pcPlus4[31:28], ifId.instruction[25:0], 2'b00};

    registerFile registers (
        .clock(clock), .reset(reset),
        .readAddressA(idRs), .readAddressB(idRt),
        .writeAddress(memWb.destination), .writeEnable(memWb.regWrite),
        .writeData(writebackValue),
        .readDataA(regDataA), .readDataB(regDataB)
    );

    // Forwarding muxes for decode and execute
    always_comb begin
        case (idForwardA)
            fromMemory:    idOperandA = exMem.aluResult;
            fromWriteback: idOperandA = writebackValue;
            default:       idOperandA = regDataA;
        endcase
        case (idForwardB)
            fromMemory:    idOperandB = exMem.aluResult;
            fromWriteback: idOperandB = writebackValue;
            default:       idOperandB = regDataB;
        endcase
        case (exForwardA)
            fromMemory:    exOperandA = exMem.aluResult;
            fromWriteback: exOperandA = writebackValue;
            default:       exOperandA = idEx.operandA;
        endcase
        case (exForwardB)
            fromMemory:    exOperandB = exMem.aluResult;
            fromWriteback: exOperandB = writebackValue;
            default:       exOperandB = idEx.operandB;
        endcase
    end

    controlDecoder decoder (
        .instruction(ifId.instruction), .operandA(idOperandA), .operandB(idOperandB),
        .exControl(idControl), .pcSource(pcSource), .signExtend(signExtend),
        .useRs(useRs), .useRt(useRt), .branchUsesOperands(branchUsesOperands),
        .destination(idDestination)
    );

    hazardUnit hazards (
        .idRs(idRs), .idRt(idRt), .useRs(useRs), .useRt(useRt),
        .branchUsesOperands(branchUsesOperands),
        .idEx(idEx), .exMem(exMem), .memWb(memWb), .busWait(busWait),
        .idForwardA(idForwardA), .idForwardB(idForwardB),
        .exForwardA(exForwardA), .exForwardB(exForwardB),
        .stallFetch(stallFetch), .stallDecode(stallDecode),
        .stallExecute(stallExecute), .stallMemory(stallMemory),
        .flushExecute(flushExecute)
    );

    assign idExIn = '{
        control: idControl, rs: idRs, rt: idRt, destination: idDestination,
        shamt: ifId.instruction[10:6], operandA: idOperandA, operandB: idOperandB,
        immediate: immediate, linkAddress: ifId.pcPlus4 + 32'd4   // Skips the delay slot
    };

    stageRegister #(.payload_t(idExPayload_t)) idExRegister (
        .clock(clock), .reset(reset), .stall(stallExecute), .flush(flushExecute),
        .dataIn(idExIn), .dataOut(idEx)
    );

    // Execute
    assign aluOperandB = idEx.control.aluSrcImm ? idEx.immediate : exOperandB;

    alu arithmetic (
        .operation(idEx.control.aluOp), .operandA(exOperandA), .operandB(aluOperandB),
        .shamt(idEx.shamt), .result(aluResult)
    );

    assign exMemIn = '{
        memRead: idEx.control.memRead, memWrite: idEx.control.memWrite,
        regWrite: idEx.control.regWrite, memToReg: idEx.control.memToReg,
        aluResult: idEx.control.link ? idEx.linkAddress : aluResult,
        storeData: exOperandB, destination: idEx.destination
    };

    stageRegister #(.payload_t(exMemPayload_t)) exMemRegister (
        .clock(clock), .reset(reset), .stall(stallMemory), .flush(1'b0),
        .dataIn(exMemIn), .dataOut(exMem)
    );

    // Memory
    dataBusMaster dataBus (
        .clock(clock), .reset(reset),
        .memRead(exMem.memRead), .memWrite(exMem.memWrite),
        .address(exMem.aluResult), .storeData(exMem.storeData),
        .loadData(loadData), .busWait(busWait),
        .busCyc(busCyc), .busStb(busStb), .busWe(busWe), .busAddress(busAddress),
        .busWriteData(busWriteData), .busAck(busAck), .busReadData(busReadData)
    );

    assign memWbIn = '{
        regWrite: exMem.regWrite, memToReg: exMem.memToReg, loadData: loadData,
        aluResult: exMem.aluResult, destination: exMem.destination
    };

    // Frozen along with memory so the waiting access cannot slip into writeback
    stageRegister #(.payload_t(memWbPayload_t)) memWbRegister (
        .clock(clock), .reset(reset), .stall(stallMemory), .flush(1'b0),
        .dataIn(memWbIn), .dataOut(memWb)
    );

    // Writeback
    assign writebackValue = memWb.memToReg ? memWb.loadData : memWb.aluResult;

endmodule

`default_nettype wire

//--- source/dataBusMaster.sv
`default_nettype none

module dataBusMaster (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               memRead,
    input  logic                               memWrite,
    input  mipsPkg::word_t                     address,
    input  mipsPkg::word_t                     storeData,
    output mipsPkg::word_t                     loadData,
    output logic                               busWait,
    output logic                               busCyc,
    output logic                               busStb,
    output logic                               busWe,
    output logic [mipsPkg::wordAddrWidth-1:0]  busAddress,
    output mipsPkg::word_t                     busWriteData,
    input  logic                               busAck,
    input  mipsPkg::word_t                     busReadData
);
    import mipsPkg::*;

    // Set for the one cycle after ack, when the access leaves the stage
    logic done;

    assign busCyc = (memRead || memWrite) && !done;
    assign busStb = busCyc;
    assign busWe = busCyc && memWrite;
    assign busAddress = address[dataWidth-1:2];
    assign busWriteData = storeData;
    assign busWait = busCyc;   // Held through the ack cycle too

    always_ff @(posedge clock) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= busCyc && busAck;
        end
    end

    always_ff @(posedge clock) begin
        if (busCyc && busAck && !memWrite) begin
            loadData <= busReadData;
        end
    end

endmodule

`default_nettype wire

//--- source/alu.sv
`default_nettype none

module alu (
    input  mipsPkg::aluOp_t operation,
    input  mipsPkg::word_t  operandA,
    input  mipsPkg::word_t  operandB,
    input  logic [4:0]      shamt,
    output mipsPkg::word_t  result
);
    import mipsPkg::*;

    always_comb begin
        case (operation)
            aluAdd:  result = operandA + operandB;   // Wraps, no overflow trap
            aluSub:  result = operandA - operandB;
            aluAnd:  result = operandA & operandB;
            aluOr:   result = operandA | operandB;
            aluXor:  result = operandA ^ operandB;
            aluNor:  result = ~(operandA | operandB);
            aluSlt:  result = word_t'($signed(operandA) < $signed(operandB));
            aluSll:  result = operandB << shamt;
            aluSrl:  result = operandB >> shamt;
            aluLui:  result = {operandB[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/registerFile.sv
`default_nettype none

module registerFile (
    input  logic              clock,
    input  logic              reset,
    input  mipsPkg::regAddr_t readAddressA,
    input  mipsPkg::regAddr_t readAddressB,
    input  mipsPkg::regAddr_t writeAddress,
    input  logic              writeEnable,
    input  mipsPkg::word_t    writeData,
    output mipsPkg::word_t    readDataA,
    output mipsPkg::word_t    readDataB
);
    import mipsPkg::*;

    word_t registers [32];
    logic  writeValid;

    assign writeValid = writeEnable && (writeAddress != '0);   // r0 stays zero

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                registers[i] <= '0;
            end
        end else if (writeValid) begin
            registers[writeAddress] <= writeData;
        end
    end

    // Same-cycle write shows through to the read ports
    always_comb begin
        readDataA = (writeValid && writeAddress == readAddressA) ? writeData
                                                                 : registers[readAddressA];
        readDataB = (writeValid && writeAddress == readAddressB) ? writeData
                                                                 : registers[readAddressB];
    end

endmodule

`default_nettype wire

//--- source/hazardUnit.sv
`default_nettype none

module hazardUnit (
    input  mipsPkg::regAddr_t      idRs,
    input  mipsPkg::regAddr_t      idRt,
    input  logic                   useRs,
    input  logic                   useRt,
    input  logic                   branchUsesOperands,
    input  mipsPkg::idExPayload_t  idEx,
    input  mipsPkg::exMemPayload_t exMem,
    input  mipsPkg::memWbPayload_t memWb,
    input  logic                   busWait,
    output mipsPkg::forwardSel_t   idForwardA,
    output mipsPkg::forwardSel_t   idForwardB,
    output mipsPkg::forwardSel_t   exForwardA,
    output mipsPkg::forwardSel_t   exForwardB,
    output logic                   stallFetch,
    output logic                   stallDecode,
    output logic                   stallExecute,
    output logic                   stallMemory,
    output logic                   flushExecute
);
    import mipsPkg::*;

    logic exHit;       // Decode reads what execute will write
    logic memLoadHit;  // Decode reads a load still in memory
    logic decodeHold;

    // Youngest producer wins; loads in memory have no value yet
    function automatic forwardSel_t selectSource(regAddr_t source);
        if (source == '0) return fromRegister;
        if (exMem.regWrite && !exMem.memToReg && exMem.destination == source) return fromMemory;
        if (memWb.regWrite && memWb.destination == source) return fromWriteback;
        return fromRegister;
    endfunction

    function automatic logic decodeReads(regAddr_t destination);
        return destination != '0
            && ((useRs && destination == idRs) || (useRt && destination == idRt));
    endfunction

    always_comb begin
        idForwardA = selectSource(idRs);
        idForwardB = selectSource(idRt);
        exForwardA = selectSource(idEx.rs);
        exForwardB = selectSource(idEx.rt);

        exHit = idEx.control.regWrite && decodeReads(idEx.destination);
        memLoadHit = exMem.memToReg && decodeReads(exMem.destination);

        // Load-use, or a branch compare whose operand is not ready
        decodeHold = (idEx.control.memRead && exHit)
            || (branchUsesOperands && (exHit || memLoadHit));

        stallFetch = busWait || decodeHold;
        stallDecode = busWait || decodeHold;
        stallExecute = busWait;
        stallMemory = busWait;
        flushExecute = decodeHold && !busWait;
    end

endmodule

`default_nettype wire

//--- source/controlDecoder.sv
`default_nettype none

module controlDecoder (
    input  mipsPkg::word_t      instruction,
    input  mipsPkg::word_t      operandA,      // Forwarded rs value
    input  mipsPkg::word_t      operandB,      // Forwarded rt value
    output mipsPkg::exControl_t exControl,
    output mipsPkg::pcSource_t  pcSource,
    output logic                signExtend,
    output logic                useRs,
    output logic                useRt,
    output logic                branchUsesOperands,
    output mipsPkg::regAddr_t   destination
);
    import mipsPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instruction[31:26];
    assign funct = instruction[5:0];

    always_comb begin
        exControl = '0;
        pcSource = pcSequential;
        signExtend = 1'b1;
        useRs = 1'b0;
        useRt = 1'b0;
        branchUsesOperands = 1'b0;
        destination = instruction[20:16];   // rt for immediate forms

        case (opcode)
            opSpecial: begin
                destination = instruction[15:11];
                useRs = 1'b1;
                useRt = 1'b1;
                exControl.regWrite = 1'b1;
                case (funct)
                    fnAddu: exControl.aluOp = aluAdd;
                    fnSubu: exControl.aluOp = aluSub;
                    fnAnd:  exControl.aluOp = aluAnd;
                    fnOr:   exControl.aluOp = aluOr;
                    fnXor:  exControl.aluOp = aluXor;
                    fnNor:  exControl.aluOp = aluNor;
                    fnSlt:  exControl.aluOp = aluSlt;
                    fnSll, fnSrl: begin
                        exControl.aluOp = (funct == fnSll) ? aluSll : aluSrl;
                        useRs = 1'b0;   // Shift amount comes from shamt
                    end
                    fnJr: begin
                        exControl.regWrite = 1'b0;
                        useRt = 1'b0;
                        branchUsesOperands = 1'b1;
                        pcSource = pcRegister;
                    end
                    default: begin
                        // Unknown function acts as a no-op
                        exControl.regWrite = 1'b0;
                        useRs = 1'b0;
                        useRt = 1'b0;
                    end
                endcase
            end
            opAddiu, opSlti, opAndi, opOri, opXori, opLui: begin
                useRs = (opcode != opLui);
                exControl.aluSrcImm = 1'b1;
                exControl.regWrite = 1'b1;
                signExtend = (opcode == opAddiu) || (opcode == opSlti);
                case (opcode)
                    opSlti:  exControl.aluOp = aluSlt;
                    opAndi:  exControl.aluOp = aluAnd;
                    opOri:   exControl.aluOp = aluOr;
                    opXori:  exControl.aluOp = aluXor;
                    opLui:   exControl.aluOp = aluLui;
                    default: exControl.aluOp = aluAdd;
                endcase
            end
            opLw: begin
                useRs = 1'b1;
                exControl.aluSrcImm = 1'b1;
                exControl.memRead = 1'b1;
                exControl.regWrite = 1'b1;
                exControl.memToReg = 1'b1;
            end
            opSw: begin
                useRs = 1'b1;
                useRt = 1'b1;          // Store data read in execute
                exControl.aluSrcImm = 1'b1;
                exControl.memWrite = 1'b1;
            end
            opBeq, opBne: begin
                useRs = 1'b1;
                useRt = 1'b1;
                branchUsesOperands = 1'b1;
                if ((operandA == operandB) == (opcode == opBeq)) begin
                    pcSource = pcBranch;
                end
            end
            opJ: pcSource = pcJump;
            opJal: begin
                pcSource = pcJump;
                exControl.link = 1'b1;
                exControl.regWrite = 1'b1;
                destination = linkRegister;
            end
            default: ;   // Undefined opcode, no-op
        endcase
    end

endmodule

`default_nettype wire

//--- source/stageRegister.sv
`default_nettype none

module stageRegister #(
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     stall,
    input  logic     flush,
    input  payload_t dataIn,
    output payload_t dataOut
);

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            dataOut <= '0;   // Bubble, every control bit clear
        end else if (!stall) begin
            dataOut <= dataIn;
        end
    end

endmodule

`default_nettype wire

//--- source/mipsPkg.sv
`default_nettype none

package mipsPkg;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;
    localparam int wordAddrWidth = 30;

    typedef logic [dataWidth-1:0] word_t;
    typedef logic [regAddrWidth-1:0] regAddr_t;

    localparam word_t resetVector = '0;
    localparam regAddr_t linkRegister = 5'd31;   // JAL return address

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor, aluSlt, aluSll, aluSrl, aluLui
    } aluOp_t;

    typedef enum logic [1:0] {pcSequential, pcJump, pcBranch, pcRegister} pcSource_t;

    typedef enum logic [1:0] {fromRegister, fromMemory, fromWriteback} forwardSel_t;

    typedef enum logic [5:0] {
        opSpecial = 6'h00, opJ = 6'h02, opJal = 6'h03, opBeq = 6'h04, opBne = 6'h05,
        opAddiu = 6'h09, opSlti = 6'h0a, opAndi = 6'h0c, opOri = 6'h0d, opXori = 6'h0e,
        opLui = 6'h0f, opLw = 6'h23, opSw = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        fnSll = 6'h00, fnSrl = 6'h02, fnJr = 6'h08, fnAddu = 6'h21, fnSubu = 6'h23,
        fnAnd = 6'h24, fnOr = 6'h25, fnXor = 6'h26, fnNor = 6'h27, fnSlt = 6'h2a
    } funct_t;

    // All-zero value is a harmless bubble
    typedef struct packed {
        aluOp_t aluOp;
        logic   aluSrcImm;
        logic   link;      // Result is the return address
        logic   memRead;
        logic   memWrite;
        logic   regWrite;
        logic   memToReg;
    } exControl_t;

    typedef struct packed {
        word_t instruction;
        word_t pcPlus4;
    } ifIdPayload_t;

    typedef struct packed {
        exControl_t control;
        regAddr_t   rs;
        regAddr_t   rt;
        regAddr_t   destination;
        logic [4:0] shamt;
        word_t      operandA;
        word_t      operandB;
        word_t      immediate;   // Already sign or zero extended
        word_t      linkAddress;
    } idExPayload_t;

    typedef struct packed {
        logic     memRead;
        logic     memWrite;
        logic     regWrite;
        logic     memToReg;
        word_t    aluResult;   // Also the bus address for loads and stores
        word_t    storeData;
        regAddr_t destination;
    } exMemPayload_t;

    typedef struct packed {
        logic     regWrite;
        logic     memToReg;
        word_t    loadData;
        word_t    aluResult;
        regAddr_t destination;
    } memWbPayload_t;

endpackage

`default_nettype wire
